// File: hdl/turfio_cfg.svh
`ifndef TURFIO_CFG_SVH
`define TURFIO_CFG_SVH

//////////////////////////////////////////////////
// Bus widths
//////////////////////////////////////////////////
// Master address, upper nibble picks the slave
`define TURFIO_ADDR_W 16
`define TURFIO_DATA_W 32
// Low address bits seen by a slave
`define TURFIO_OFFS_W 12

//////////////////////////////////////////////////
// Address map and constants
//////////////////////////////////////////////////
// Slave select values of addr[15:12]
`define TURFIO_SLV_ID 4'd0
`define TURFIO_SLV_SYNC 4'd1
// Read value for an unmapped slave select
`define TURFIO_BAD_DATA 32'hBADACCE5
// ASCII TFIO
`define TURFIO_IDENT 32'h5446_494F
// Date field zero, then major 0, minor 2, revision 20
`define TURFIO_VERSION 32'h0000_0214
// Sync period is 2**4 = 16 clocks
`define TURFIO_SYNC_PERIOD_W 4

`endif

// File: hdl/turfio_bus_pkg.sv
`include "turfio_cfg.svh"

package turfio_bus_pkg;

    // Master side address
    // Slave select lives in the top nibble
    typedef logic [`TURFIO_ADDR_W-1:0] bus_addr_t;

    // Read and write data, both directions
    typedef logic [`TURFIO_DATA_W-1:0] bus_data_t;

    // Register offset inside one slave
    typedef logic [`TURFIO_OFFS_W-1:0] reg_offs_t;

    // Arbiter FSM
    // IDLE picks a master, WAIT holds for the slave, DONE acks the master
    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_WAIT,
        ARB_DONE
    } arb_state_e;

endpackage

// File: hdl/turfio_reg_pkg.sv
`include "turfio_cfg.svh"

package turfio_reg_pkg;

    // Sync strobe position inside the 16 clock period
    typedef logic [`TURFIO_SYNC_PERIOD_W-1:0] sync_offs_t;

    // Free running clock count
    typedef logic [47:0] clk_count_t;

    // Id/ctrl slave register map
    typedef enum logic [`TURFIO_OFFS_W-1:0] {
        REG_IDENT     = `TURFIO_OFFS_W'(0),
        REG_VERSION   = `TURFIO_OFFS_W'(1),
        REG_CTRL      = `TURFIO_OFFS_W'(2),
        REG_SYNC_OFFS = `TURFIO_OFFS_W'(3)
    } reg_id_e;

    // Sync counter slave register map
    typedef enum logic [`TURFIO_OFFS_W-1:0] {
        REG_COUNT_LO = `TURFIO_OFFS_W'(0),
        REG_COUNT_HI = `TURFIO_OFFS_W'(1)
    } reg_sync_e;

endpackage

// File: hdl/turfio_bus_arbiter.sv
`timescale 1ns/10ps
`include "turfio_cfg.svh"

module turfio_bus_arbiter (
    input  logic                      reset_i,
    input  logic                      init_clk,
    // Gigabit command master
    input  logic                      gtp_cyc_i,
    input  logic                      gtp_we_i,
    input  turfio_bus_pkg::bus_addr_t gtp_addr_i,
    input  turfio_bus_pkg::bus_data_t gtp_wdata_i,
    output logic                      gtp_ack_o,
    output turfio_bus_pkg::bus_data_t gtp_rdata_o,
    // Debug master
    input  logic                      dbg_cyc_i,
    input  logic                      dbg_we_i,
    input  turfio_bus_pkg::bus_addr_t dbg_addr_i,
    input  turfio_bus_pkg::bus_data_t dbg_wdata_i,
    output logic                      dbg_ack_o,
    output turfio_bus_pkg::bus_data_t dbg_rdata_o,
    // Shared slave lines
    output logic                      bus_we_o,
    output turfio_bus_pkg::reg_offs_t bus_offs_o,
    output turfio_bus_pkg::bus_data_t bus_wdata_o,
    // Id/ctrl slave
    output logic                      id_stb_o,
    input  logic                      id_ack_i,
    input  turfio_bus_pkg::bus_data_t id_rdata_i,
    // Sync counter slave
    output logic                      sync_stb_o,
    input  logic                      sync_ack_i,
    input  turfio_bus_pkg::bus_data_t sync_rdata_i
);
    import turfio_bus_pkg::*;

    arb_state_e state_q;
    // Granted master while busy, last served master once idle
    logic       last_gtp_q;
    logic       pick_gtp;
    bus_addr_t  sel_addr;
    logic [`TURFIO_ADDR_W-`TURFIO_OFFS_W-1:0] sel_slv;
    logic       sel_mapped;
    // Strobes, plus a local stand-in slave for unmapped selects
    logic       id_stb_q;
    logic       sync_stb_q;
    logic       bad_stb_q;
    logic       bad_ack_q;
    // Latched request and answer
    logic       we_q;
    reg_offs_t  offs_q;
    bus_data_t  wdata_q;
    bus_data_t  rdata_q;

    //////////////////////////////////////////////////
    // Round robin pick and decode
    //////////////////////////////////////////////////
    // gtp wins alone, or on a tie when dbg went last
    assign pick_gtp = gtp_cyc_i && (!dbg_cyc_i || !last_gtp_q);
    assign sel_addr = pick_gtp ? gtp_addr_i : dbg_addr_i;
    assign sel_slv = sel_addr[`TURFIO_ADDR_W-1:`TURFIO_OFFS_W];
    assign sel_mapped = (sel_slv == `TURFIO_SLV_ID) || (sel_slv == `TURFIO_SLV_SYNC);

    //////////////////////////////////////////////////
    // FSM
    //////////////////////////////////////////////////
    always_ff @(posedge init_clk) begin
        if (reset_i) begin
            state_q    <= ARB_IDLE;
            last_gtp_q <= 1'b0;
            id_stb_q   <= 1'b0;
            sync_stb_q <= 1'b0;
            bad_stb_q  <= 1'b0;
            bad_ack_q  <= 1'b0;
        end else begin
            // Strobes last a single clock
            id_stb_q   <= 1'b0;
            sync_stb_q <= 1'b0;
            bad_stb_q  <= 1'b0;
            // Unmapped answer one clock after its strobe, like a real slave
            bad_ack_q  <= bad_stb_q;
            case (state_q)
                ARB_IDLE: begin
                    if (gtp_cyc_i || dbg_cyc_i) begin
                        last_gtp_q <= pick_gtp;
                        id_stb_q   <= (sel_slv == `TURFIO_SLV_ID);
                        sync_stb_q <= (sel_slv == `TURFIO_SLV_SYNC);
                        bad_stb_q  <= !sel_mapped;
                        state_q    <= ARB_WAIT;
                    end
                end
                ARB_WAIT: begin
                    if (id_ack_i || sync_ack_i || bad_ack_q) begin
                        state_q <= ARB_DONE;
                    end
                end
                // Ack pulse goes out here
                default: state_q <= ARB_IDLE;
            endcase
        end
    end

    // Request latch follows the pick until the FSM leaves idle
    always_ff @(posedge init_clk) begin
        if (state_q == ARB_IDLE) begin
            we_q    <= pick_gtp ? gtp_we_i : dbg_we_i;
            offs_q  <= sel_addr[`TURFIO_OFFS_W-1:0];
            wdata_q <= pick_gtp ? gtp_wdata_i : dbg_wdata_i;
        end
        // Last value taken in WAIT is the one handed to the master
        if (state_q == ARB_WAIT) begin
            if (id_ack_i) begin
                rdata_q <= id_rdata_i;
            end else if (sync_ack_i) begin
                rdata_q <= sync_rdata_i;
            end else begin
                rdata_q <= `TURFIO_BAD_DATA;
            end
        end
    end

    //////////////////////////////////////////////////
    // Outputs
    //////////////////////////////////////////////////
    assign bus_we_o    = we_q;
    assign bus_offs_o  = offs_q;
    assign bus_wdata_o = wdata_q;
    assign id_stb_o    = id_stb_q;
    assign sync_stb_o  = sync_stb_q;

    // Only the granted master sees ack and data
    assign gtp_ack_o   = (state_q == ARB_DONE) && last_gtp_q;
    assign dbg_ack_o   = (state_q == ARB_DONE) && !last_gtp_q;
    assign gtp_rdata_o = gtp_ack_o ? rdata_q : '0;
    assign dbg_rdata_o = dbg_ack_o ? rdata_q : '0;

endmodule

// File: hdl/turfio_id_ctrl.sv
`timescale 1ns/10ps
`include "turfio_cfg.svh"

module turfio_id_ctrl (
    input  logic                       reset_i,
    input  logic                       init_clk,
    // Register bus
    input  logic                       stb_i,
    input  logic                       we_i,
    input  turfio_bus_pkg::reg_offs_t  offs_i,
    input  turfio_bus_pkg::bus_data_t  wdata_i,
    output logic                       ack_o,
    output turfio_bus_pkg::bus_data_t  rdata_o,
    // Crate power control
    output logic                       enable_crate_o,
    output logic                       enable_3v3_o,
    // To the sync counter
    output turfio_reg_pkg::sync_offs_t sync_offset_o
);
    import turfio_bus_pkg::*;
    import turfio_reg_pkg::*;

    // Bit 0 crate enable, bit 1 3.3 V enable
    logic [1:0] ctrl_q;
    sync_offs_t sync_offs_q;
    bus_data_t  rdata_nxt;
    logic       wr_en;

    assign wr_en = stb_i && we_i;

    //////////////////////////////////////////////////
    // Read mux
    //////////////////////////////////////////////////
    always_comb begin
        rdata_nxt = '0;
        case (offs_i)
            REG_IDENT:     rdata_nxt = `TURFIO_IDENT;
            REG_VERSION:   rdata_nxt = `TURFIO_VERSION;
            REG_CTRL:      rdata_nxt[1:0] = ctrl_q;
            REG_SYNC_OFFS: rdata_nxt[`TURFIO_SYNC_PERIOD_W-1:0] = sync_offs_q;
            // Holes in the map read as zero
            default:       rdata_nxt = '0;
        endcase
    end

    //////////////////////////////////////////////////
    // Writable registers
    //////////////////////////////////////////////////
    always_ff @(posedge init_clk) begin
        if (reset_i) begin
            ack_o       <= 1'b0;
            ctrl_q      <= 2'b00;
            sync_offs_q <= '0;
        end else begin
            // Fixed single clock answer
            ack_o <= stb_i;
            if (wr_en) begin
                case (offs_i)
                    REG_CTRL:      ctrl_q <= wdata_i[1:0];
                    REG_SYNC_OFFS: sync_offs_q <= wdata_i[`TURFIO_SYNC_PERIOD_W-1:0];
                    // Ident, version and holes drop the write
                    default: ;
                endcase
            end
        end
    end

    // Read data is only looked at with ack
    always_ff @(posedge init_clk) begin
        if (stb_i) begin
            rdata_o <= rdata_nxt;
        end
    end

    assign enable_crate_o = ctrl_q[0];
    assign enable_3v3_o   = ctrl_q[1];
    assign sync_offset_o  = sync_offs_q;

endmodule

// File: hdl/turfio_sync_count.sv
`timescale 1ns/10ps
`include "turfio_cfg.svh"

module turfio_sync_count (
    input  logic                       reset_i,
    input  logic                       init_clk,
    // Register bus, read only
    input  logic                       stb_i,
    input  logic                       we_i,
    input  turfio_bus_pkg::reg_offs_t  offs_i,
    output logic                       ack_o,
    output turfio_bus_pkg::bus_data_t  rdata_o,
    // Sync position from the id/ctrl slave
    input  turfio_reg_pkg::sync_offs_t sync_offset_i,
    output logic                       sync_o
);
    import turfio_bus_pkg::*;
    import turfio_reg_pkg::*;

    // Count bits above the low data word
    localparam int HI_W = $bits(clk_count_t) - `TURFIO_DATA_W;

    clk_count_t      count_q;
    clk_count_t      count_nxt;
    logic [HI_W-1:0] shadow_q;
    logic            rd_en;
    bus_data_t       rdata_nxt;

    assign count_nxt = count_q + 1'b1;
    assign rd_en = stb_i && !we_i;

    //////////////////////////////////////////////////
    // Counter and sync strobe
    //////////////////////////////////////////////////
    always_ff @(posedge init_clk) begin
        if (reset_i) begin
            count_q <= '0;
            sync_o  <= 1'b0;
            ack_o   <= 1'b0;
        end else begin
            count_q <= count_nxt;
            // Compare ahead so sync_o lines up with count_q
            sync_o  <= (count_nxt[`TURFIO_SYNC_PERIOD_W-1:0] == sync_offset_i);
            // Writes still get acked, they just do nothing
            ack_o   <= stb_i;
        end
    end

    //////////////////////////////////////////////////
    // Coherent readout
    //////////////////////////////////////////////////
    always_comb begin
        rdata_nxt = '0;
        if (!we_i) begin
            case (offs_i)
                REG_COUNT_LO: rdata_nxt = count_q[`TURFIO_DATA_W-1:0];
                // Upper bits as they were at the last low read
                REG_COUNT_HI: rdata_nxt[HI_W-1:0] = shadow_q;
                default:      rdata_nxt = '0;
            endcase
        end
    end

    always_ff @(posedge init_clk) begin
        if (stb_i) begin
            rdata_o <= rdata_nxt;
        end
        // Low read freezes the upper half in the same clock
        if (rd_en && (offs_i == REG_COUNT_LO)) begin
            shadow_q <= count_q[$bits(clk_count_t)-1:`TURFIO_DATA_W];
        end
    end

endmodule

// File: hdl/pueo_turfio_regs.sv
`timescale 1ns/10ps

module pueo_turfio_regs (
    input  logic                      init_clk,
    input  logic                      reset_i,
    // Debug master
    input  logic                      dbg_cyc_i,
    input  logic                      dbg_we_i,
    input  turfio_bus_pkg::bus_addr_t dbg_addr_i,
    input  turfio_bus_pkg::bus_data_t dbg_wdata_i,
    output logic                      dbg_ack_o,
    output turfio_bus_pkg::bus_data_t dbg_rdata_o,
    // Gigabit command master
    input  logic                      gtp_cyc_i,
    input  logic                      gtp_we_i,
    input  turfio_bus_pkg::bus_addr_t gtp_addr_i,
    input  turfio_bus_pkg::bus_data_t gtp_wdata_i,
    output logic                      gtp_ack_o,
    output turfio_bus_pkg::bus_data_t gtp_rdata_o,
    // Crate control and sync
    output logic                      enable_crate_o,
    output logic                      enable_3v3_o,
    output logic                      sync_o
);
    import turfio_bus_pkg::*;
    import turfio_reg_pkg::*;

    // Shared slave lines
    logic       bus_we;
    reg_offs_t  bus_offs;
    bus_data_t  bus_wdata;
    // Per slave strobe and answer
    logic       id_stb;
    logic       id_ack;
    bus_data_t  id_rdata;
    logic       sync_stb;
    logic       sync_ack;
    bus_data_t  sync_rdata;
    // Id/ctrl to sync counter
    sync_offs_t sync_offset;

    turfio_bus_arbiter u_arbiter (
        .reset_i      (reset_i),
        .init_clk     (init_clk),
        .gtp_cyc_i    (gtp_cyc_i),
        .gtp_we_i     (gtp_we_i),
        .gtp_addr_i   (gtp_addr_i),
        .gtp_wdata_i  (gtp_wdata_i),
        .gtp_ack_o    (gtp_ack_o),
        .gtp_rdata_o  (gtp_rdata_o),
        .dbg_cyc_i    (dbg_cyc_i),
        .dbg_we_i     (dbg_we_i),
        .dbg_addr_i   (dbg_addr_i),
        .dbg_wdata_i  (dbg_wdata_i),
        .dbg_ack_o    (dbg_ack_o),
        .dbg_rdata_o  (dbg_rdata_o),
        .bus_we_o     (bus_we),
        .bus_offs_o   (bus_offs),
        .bus_wdata_o  (bus_wdata),
        .id_stb_o     (id_stb),
        .id_ack_i     (id_ack),
        .id_rdata_i   (id_rdata),
        .sync_stb_o   (sync_stb),
        .sync_ack_i   (sync_ack),
        .sync_rdata_i (sync_rdata)
    );

    // Slave 0
    turfio_id_ctrl u_id_ctrl (
        .reset_i        (reset_i),
        .init_clk       (init_clk),
        .stb_i          (id_stb),
        .we_i           (bus_we),
        .offs_i         (bus_offs),
        .wdata_i        (bus_wdata),
        .ack_o          (id_ack),
        .rdata_o        (id_rdata),
        .enable_crate_o (enable_crate_o),
        .enable_3v3_o   (enable_3v3_o),
        .sync_offset_o  (sync_offset)
    );

    // Slave 1, takes no write data
    turfio_sync_count u_sync_count (
        .reset_i       (reset_i),
        .init_clk      (init_clk),
        .stb_i         (sync_stb),
        .we_i          (bus_we),
        .offs_i        (bus_offs),
        .ack_o         (sync_ack),
        .rdata_o       (sync_rdata),
        .sync_offset_i (sync_offset),
        .sync_o        (sync_o)
    );

endmodule

// File: verif/tb_clkgen.sv
`timescale 1ns/10ps

module tb_clkgen #(
    parameter real PERIOD_NS    = 4.0,
    parameter int  RESET_CYCLES = 5
) (
    output logic clk_o,
    output logic reset_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;
    end

    // Reset held over the first edges, released on an edge
    initial begin
        reset_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        reset_o <= 1'b0;
    end

endmodule

// File: verif/turfio_regs_sva.sv
`timescale 1ns/10ps
`include "turfio_cfg.svh"

module turfio_regs_sva (
    input logic                             init_clk,
    input logic                             reset_i,
    input logic                             dbg_cyc_i,
    input logic                             dbg_ack_o,
    input logic                             gtp_cyc_i,
    input logic                             gtp_ack_o,
    input logic                             enable_crate_o,
    input logic                             enable_3v3_o,
    input logic                             sync_o,
    input logic [`TURFIO_SYNC_PERIOD_W-1:0] sync_offset_i
);

    // Clocks since the sync offset last moved
    logic [5:0]                       stable_cnt;
    logic [`TURFIO_SYNC_PERIOD_W-1:0] offs_prev;

    always_ff @(posedge init_clk) begin
        offs_prev <= sync_offset_i;
        if (reset_i || (sync_offset_i != offs_prev)) begin
            stable_cnt <= '0;
        end else if (stable_cnt != '1) begin
            stable_cnt <= stable_cnt + 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // Master handshake
    //////////////////////////////////////////////////
    assert property (@(posedge init_clk) disable iff (reset_i) gtp_ack_o |=> !gtp_ack_o)
        else $error("gtp ack longer than one cycle");
    assert property (@(posedge init_clk) disable iff (reset_i) dbg_ack_o |=> !dbg_ack_o)
        else $error("dbg ack longer than one cycle");
    assert property (@(posedge init_clk) disable iff (reset_i) gtp_ack_o |-> gtp_cyc_i)
        else $error("gtp ack without cyc");
    assert property (@(posedge init_clk) disable iff (reset_i) dbg_ack_o |-> dbg_cyc_i)
        else $error("dbg ack without cyc");

    // Lone request into an idle arbiter
    assert property (@(posedge init_clk) disable iff (reset_i)
        $rose(gtp_cyc_i) && !$past(dbg_cyc_i) && !dbg_cyc_i
        |-> !gtp_ack_o ##1 !gtp_ack_o ##1 !gtp_ack_o ##1 gtp_ack_o)
        else $error("gtp ack latency not three cycles");
    assert property (@(posedge init_clk) disable iff (reset_i)
        $rose(dbg_cyc_i) && !$past(gtp_cyc_i) && !gtp_cyc_i
        |-> !dbg_ack_o ##1 !dbg_ack_o ##1 !dbg_ack_o ##1 dbg_ack_o)
        else $error("dbg ack latency not three cycles");

    //////////////////////////////////////////////////
    // Sync period and reset values
    //////////////////////////////////////////////////
    assert property (@(posedge init_clk) disable iff (reset_i)
        sync_o && (stable_cnt >= 6'd20) |-> $past(sync_o, 16) && !$past(sync_o, 1))
        else $error("sync_o period not 16 cycles");
    assert property (@(posedge init_clk)
        $fell(reset_i) |-> !enable_crate_o && !enable_3v3_o && !sync_o && !dbg_ack_o && !gtp_ack_o)
        else $error("outputs not low after reset");

endmodule

bind pueo_turfio_regs turfio_regs_sva sva0 (
    .init_clk       (init_clk),
    .reset_i        (reset_i),
    .dbg_cyc_i      (dbg_cyc_i),
    .dbg_ack_o      (dbg_ack_o),
    .gtp_cyc_i      (gtp_cyc_i),
    .gtp_ack_o      (gtp_ack_o),
    .enable_crate_o (enable_crate_o),
    .enable_3v3_o   (enable_3v3_o),
    .sync_o         (sync_o),
    .sync_offset_i  (sync_offset)
);

// File: verif/tb_pueo_turfio_regs.sv
`timescale 1ns/10ps
`include "turfio_cfg.svh"

module tb_pueo_turfio_regs;
    import turfio_bus_pkg::*;
    import turfio_reg_pkg::*;

    localparam int CLK_NS        = 4;
    localparam int N_ACCESSES    = 24;
    // Worst case per access incl. random gap and a wait behind the other master
    localparam int ACCESS_CYCLES = 20;
    localparam int SYNC_CYCLES   = 64;
    localparam int WATCHDOG_NS   = (N_ACCESSES * ACCESS_CYCLES + SYNC_CYCLES + 40) * CLK_NS;

    logic      clk;
    logic      reset;
    logic      dbg_cyc, dbg_we, gtp_cyc, gtp_we;
    bus_addr_t dbg_addr, gtp_addr;
    bus_data_t dbg_wdata, gtp_wdata;
    logic      dbg_ack, gtp_ack;
    bus_data_t dbg_rdata, gtp_rdata;
    logic      enable_crate, enable_3v3, sync;
    logic [31:0] lcg_state;
    logic [31:0] tb_cycle;
    // 1 for a gtp ack, 0 for a dbg ack
    logic      grant_log[$];

    tb_clkgen #(.PERIOD_NS(CLK_NS), .RESET_CYCLES(5)) clkgen0 (
        .clk_o   (clk),
        .reset_o (reset)
    );

    pueo_turfio_regs dut0 (
        .init_clk       (clk),
        .reset_i        (reset),
        .dbg_cyc_i      (dbg_cyc),
        .dbg_we_i       (dbg_we),
        .dbg_addr_i     (dbg_addr),
        .dbg_wdata_i    (dbg_wdata),
        .dbg_ack_o      (dbg_ack),
        .dbg_rdata_o    (dbg_rdata),
        .gtp_cyc_i      (gtp_cyc),
        .gtp_we_i       (gtp_we),
        .gtp_addr_i     (gtp_addr),
        .gtp_wdata_i    (gtp_wdata),
        .gtp_ack_o      (gtp_ack),
        .gtp_rdata_o    (gtp_rdata),
        .enable_crate_o (enable_crate),
        .enable_3v3_o   (enable_3v3),
        .sync_o         (sync)
    );

    // Mirrors the free running count, zero in the first cycle after reset
    always @(posedge clk) begin
        if (reset) tb_cycle <= '0;
        else tb_cycle <= tb_cycle + 1;
    end

    always @(negedge clk) begin
        if (gtp_ack) grant_log.push_back(1'b1);
        if (dbg_ack) grant_log.push_back(1'b0);
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired, the test did not finish in time");
        $display("CHECKS FAILED");
        $fatal(1);
    end

    //////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////
    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic bus_addr_t make_addr(logic [3:0] slv, reg_offs_t offs);
        return {slv, offs};
    endfunction

    task automatic check_value(string name, bus_data_t got, bus_data_t exp);
        assert (got === exp) else begin
            $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            $display("CHECKS FAILED");
            $fatal(1);
        end
    endtask

    task automatic fail_plain(string what);
        $display("%s", what);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    // One bus access from either master, waits for ack
    task automatic bus_access(input logic use_gtp, input logic we, input bus_addr_t addr,
                              input bus_data_t wdata, output bus_data_t rdata);
        int   waited;
        logic got_ack;
        waited = 0;
        @(posedge clk);
        if (use_gtp) begin
            gtp_cyc <= 1'b1;
            gtp_we <= we;
            gtp_addr <= addr;
            gtp_wdata <= wdata;
        end else begin
            dbg_cyc <= 1'b1;
            dbg_we <= we;
            dbg_addr <= addr;
            dbg_wdata <= wdata;
        end
        do begin
            @(negedge clk);
            waited++;
            got_ack = use_gtp ? gtp_ack : dbg_ack;
            if (waited > ACCESS_CYCLES) fail_plain("No ack from the bus within the access bound");
        end while (!got_ack);
        rdata = use_gtp ? gtp_rdata : dbg_rdata;
        @(posedge clk);
        if (use_gtp) gtp_cyc <= 1'b0;
        else dbg_cyc <= 1'b0;
    endtask

    task automatic read_check(logic use_gtp, bus_addr_t addr, bus_data_t exp, string name);
        bus_data_t rd;
        bus_access(use_gtp, 1'b0, addr, '0, rd);
        check_value(name, rd, exp);
    endtask

    task automatic random_gap();
        repeat (next_rand() % 4) @(posedge clk);
    endtask

    //////////////////////////////////////////////////
    // Tests
    //////////////////////////////////////////////////
    initial begin
        bus_data_t  rd, lo, hi, wval;
        logic [47:0] count_a, count_b;
        sync_offs_t offs;
        dbg_cyc <= 1'b0;
        dbg_we <= 1'b0;
        dbg_addr <= '0;
        dbg_wdata <= '0;
        gtp_cyc <= 1'b0;
        gtp_we <= 1'b0;
        gtp_addr <= '0;
        gtp_wdata <= '0;
        lcg_state = 32'hdef8;
        @(negedge reset);
        repeat (2) @(posedge clk);

        // Identifier and version from both masters
        read_check(1'b0, make_addr(`TURFIO_SLV_ID, REG_IDENT), `TURFIO_IDENT, "dbg_rdata_o");
        random_gap();
        read_check(1'b1, make_addr(`TURFIO_SLV_ID, REG_IDENT), `TURFIO_IDENT, "gtp_rdata_o");
        random_gap();
        read_check(1'b0, make_addr(`TURFIO_SLV_ID, REG_VERSION), `TURFIO_VERSION, "dbg_rdata_o");
        random_gap();
        read_check(1'b1, make_addr(`TURFIO_SLV_ID, REG_VERSION), `TURFIO_VERSION, "gtp_rdata_o");

        // Control keeps two bits and drives the enables
        wval = next_rand();
        bus_access(1'b1, 1'b1, make_addr(`TURFIO_SLV_ID, REG_CTRL), wval, rd);
        random_gap();
        read_check(1'b0, make_addr(`TURFIO_SLV_ID, REG_CTRL), {30'd0, wval[1:0]}, "dbg_rdata_o");
        check_value("enable_crate_o", {31'd0, enable_crate}, {31'd0, wval[0]});
        check_value("enable_3v3_o", {31'd0, enable_3v3}, {31'd0, wval[1]});
        bus_access(1'b0, 1'b1, make_addr(`TURFIO_SLV_ID, REG_IDENT), next_rand(), rd);
        read_check(1'b1, make_addr(`TURFIO_SLV_ID, REG_IDENT), `TURFIO_IDENT, "gtp_rdata_o");

        // Unmapped slave selects
        read_check(1'b0, make_addr(4'd2, 12'h000), `TURFIO_BAD_DATA, "dbg_rdata_o");
        random_gap();
        read_check(1'b1, make_addr(4'd3, 12'h004), `TURFIO_BAD_DATA, "gtp_rdata_o");

        // Both masters at once, two accesses each
        repeat (2) @(posedge clk);
        grant_log.delete();
        fork
            begin
                read_check(1'b1, make_addr(`TURFIO_SLV_ID, REG_VERSION), `TURFIO_VERSION,
                           "gtp_rdata_o");
                read_check(1'b1, make_addr(`TURFIO_SLV_ID, REG_VERSION), `TURFIO_VERSION,
                           "gtp_rdata_o");
            end
            begin
                read_check(1'b0, make_addr(`TURFIO_SLV_ID, REG_IDENT), `TURFIO_IDENT,
                           "dbg_rdata_o");
                read_check(1'b0, make_addr(`TURFIO_SLV_ID, REG_IDENT), `TURFIO_IDENT,
                           "dbg_rdata_o");
            end
        join
        assert (grant_log.size() == 4)
            else fail_plain("Wrong number of acks with both masters busy");
        // gtp made the last access before the tie, so dbg goes first
        assert (grant_log[0] == 1'b0)
            else fail_plain("dbg did not win the tie after a gtp access");
        for (int i = 1; i < 4; i++) begin
            assert (grant_log[i] != grant_log[i-1]) else fail_plain("Masters did not alternate");
        end

        // Coherent 48 bit count, two pairs
        bus_access(1'b0, 1'b0, make_addr(`TURFIO_SLV_SYNC, REG_COUNT_LO), '0, lo);
        bus_access(1'b0, 1'b0, make_addr(`TURFIO_SLV_SYNC, REG_COUNT_HI), '0, hi);
        count_a = {hi[15:0], lo};
        random_gap();
        bus_access(1'b1, 1'b0, make_addr(`TURFIO_SLV_SYNC, REG_COUNT_LO), '0, lo);
        bus_access(1'b1, 1'b0, make_addr(`TURFIO_SLV_SYNC, REG_COUNT_HI), '0, hi);
        count_b = {hi[15:0], lo};
        assert (count_b > count_a) else fail_plain("Clock count did not increase between reads");

        // Sync strobe position after an offset write
        offs = sync_offs_t'(next_rand() % 16);
        bus_access(1'b0, 1'b1, make_addr(`TURFIO_SLV_ID, REG_SYNC_OFFS), {28'd0, offs}, rd);
        repeat (3) @(negedge clk);
        for (int i = 0; i < SYNC_CYCLES; i++) begin
            @(negedge clk);
            check_value("sync_o", {31'd0, sync}, {31'd0, tb_cycle[3:0] == offs});
        end

        repeat (2) @(posedge clk);
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

// File: flist.f
+incdir+hdl
hdl/turfio_bus_pkg.sv
hdl/turfio_reg_pkg.sv
hdl/turfio_bus_arbiter.sv
hdl/turfio_id_ctrl.sv
hdl/turfio_sync_count.sv
hdl/pueo_turfio_regs.sv
verif/tb_clkgen.sv
verif/turfio_regs_sva.sv
verif/tb_pueo_turfio_regs.sv

// File: Makefile
VERILATOR  ?= verilator
FLIST      := flist.f
TOP        := tb_pueo_turfio_regs
RTL_TOP    := pueo_turfio_regs
FLAGS      := --binary --timing --assert
LINT_FLAGS := --lint-only --timing
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := ALL CHECKS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
